// File: Makefile
TOP = rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module rename_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/rename_tb.sv
// table-driven testbench with consumer model, compare tasks and watchdog

`default_nettype none

module rename_tb
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT = 20;

    typedef struct {
        string name;
        op_t   op;
        lreg_t rs1;
        lreg_t rs2;
        lreg_t rd;
        logic  rd_valid;
        imm_t  imm;
        logic  stall;
        logic  commit_valid;
        preg_t commit_preg;
        logic  wb_valid;
        preg_t wb_preg;
        preg_t exp_prs1;
        preg_t exp_prs2;
        preg_t exp_prd;
        preg_t exp_old_prd;
        logic  exp_busy1;
        logic  exp_busy2;
    } test_t;

    logic clk = 1'b0;
    logic rst;

    logic  in_req;
    logic  in_ack;
    op_t   in_op;
    lreg_t in_rs1;
    lreg_t in_rs2;
    lreg_t in_rd;
    logic  in_rd_valid;
    imm_t  in_imm;

    logic  out_req;
    logic  out_ack;
    op_t   out_op;
    preg_t out_prs1;
    preg_t out_prs2;
    preg_t out_prd;
    preg_t out_old_prd;
    logic  out_rd_valid;
    imm_t  out_imm;
    logic  out_rs1_busy;
    logic  out_rs2_busy;

    logic  commit_valid;
    preg_t commit_preg;
    logic  wb_valid;
    preg_t wb_preg;

    test_t tests[$];
    test_t cur;
    logic  table_ready = 1'b0;
    int    errors = 0;
    int    outputs_seen = 0;

    always #10 clk = ~clk;

    rename_top UUT (
        .clk          (clk),
        .rst          (rst),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_op        (in_op),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_rd        (in_rd),
        .in_rd_valid  (in_rd_valid),
        .in_imm       (in_imm),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_op       (out_op),
        .out_prs1     (out_prs1),
        .out_prs2     (out_prs2),
        .out_prd      (out_prd),
        .out_old_prd  (out_old_prd),
        .out_rd_valid (out_rd_valid),
        .out_imm      (out_imm),
        .out_rs1_busy (out_rs1_busy),
        .out_rs2_busy (out_rs2_busy),
        .commit_valid (commit_valid),
        .commit_preg  (commit_preg),
        .wb_valid     (wb_valid),
        .wb_preg      (wb_preg)
    );

    task automatic check_preg(input string name, input preg_t exp, input preg_t act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input op_t exp, input op_t act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_imm(input string name, input imm_t exp, input imm_t act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // starts a new table row
    task automatic set_uop(input string name, input op_t op, input lreg_t rs1,
                           input lreg_t rs2, input lreg_t rd, input logic rd_valid,
                           input imm_t imm);
        cur = '{name: name, op: op, rs1: rs1, rs2: rs2, rd: rd, rd_valid: rd_valid,
                imm: imm, default: '0};
    endtask

    // micro-op must stall on an empty free list until this commit
    task automatic stall_until_commit(input preg_t preg);
        cur.stall        = 1'b1;
        cur.commit_valid = 1'b1;
        cur.commit_preg  = preg;
    endtask

    task automatic add_wb(input preg_t preg);
        cur.wb_valid = 1'b1;
        cur.wb_preg  = preg;
    endtask

    task automatic set_exp(input preg_t prs1, input preg_t prs2, input preg_t prd,
                           input preg_t old_prd, input logic busy1, input logic busy2);
        cur.exp_prs1    = prs1;
        cur.exp_prs2    = prs2;
        cur.exp_prd     = prd;
        cur.exp_old_prd = old_prd;
        cur.exp_busy1   = busy1;
        cur.exp_busy2   = busy2;
        tests.push_back(cur);
    endtask

    task automatic build_table();
        set_uop("reset_read", OP_ADD, 5, 7, 0, 1'b0, 32'h0000_1234);
        set_exp(5, 7, 0, 0, 1'b0, 1'b0);
        set_uop("first_dest", OP_ADDI, 1, 0, 1, 1'b1, 32'h0000_0010);
        set_exp(1, 0, 32, 1, 1'b0, 1'b0);
        set_uop("second_dest", OP_ADD, 2, 3, 2, 1'b1, 32'h0000_0020);
        set_exp(2, 3, 33, 2, 1'b0, 1'b0);
        set_uop("third_dest", OP_SUB, 4, 6, 3, 1'b1, 32'h0000_0030);
        set_exp(4, 6, 34, 3, 1'b0, 1'b0);
        set_uop("read_renamed_rd0", OP_AND, 1, 2, 0, 1'b1, 32'hdead_beef);
        set_exp(32, 33, 0, 0, 1'b1, 1'b1);
        set_uop("rd_invalid", OP_OR, 3, 0, 5, 1'b0, 32'h0000_0050);
        set_exp(34, 0, 0, 0, 1'b1, 1'b0);
        set_uop("rewrite_x1", OP_XOR, 1, 1, 1, 1'b1, 32'h0000_0060);
        set_exp(32, 32, 35, 32, 1'b1, 1'b1);
        // writeback in the same cycle already reads not busy
        set_uop("wb_same_cycle", OP_SLL, 2, 3, 0, 1'b0, 32'h0000_0070);
        add_wb(33);
        set_exp(33, 34, 0, 0, 1'b0, 1'b1);
        set_uop("after_wb", OP_SRL, 2, 1, 0, 1'b0, 32'h0000_0080);
        set_exp(33, 35, 0, 0, 1'b0, 1'b1);
        set_uop("wb_x1", OP_SRA, 1, 5, 0, 1'b0, 32'h0000_0090);
        add_wb(35);
        set_exp(35, 5, 0, 0, 1'b0, 1'b0);
        // x4..x31 take the last 28 free registers 36..63
        for (int i = 0; i < 28; i++)
        begin
            set_uop($sformatf("fill_%0d", i), OP_ADDI, 0, 0, lreg_t'(4 + i), 1'b1,
                    imm_t'(32'h100 + i));
            if (i == 27)
            begin
                add_wb(40);
            end
            set_exp(0, 0, preg_t'(36 + i), preg_t'(4 + i), 1'b0, 1'b0);
        end
        set_uop("stall_empty", OP_LUI, 0, 0, 9, 1'b1, 32'hcafe_0000);
        stall_until_commit(40);
        set_exp(0, 0, 40, 41, 1'b0, 1'b0);
        set_uop("after_refill", OP_STORE, 9, 8, 0, 1'b0, 32'h0000_0004);
        set_exp(40, 40, 0, 0, 1'b1, 1'b1);
    endtask

    task automatic apply_test(input test_t t);
        int waited;
        @(posedge clk);
        #2;
        in_op       = t.op;
        in_rs1      = t.rs1;
        in_rs2      = t.rs2;
        in_rd       = t.rd;
        in_rd_valid = t.rd_valid;
        in_imm      = t.imm;
        in_req      = 1'b1;
        if (t.stall)
        begin
            repeat (4)
            begin
                @(posedge clk);
                #1;
                check_bit({t.name, " stalled in_ack"}, 1'b0, in_ack);
            end
        end
        if (t.commit_valid)
        begin
            @(posedge clk);
            #2;
            commit_valid = 1'b1;
            commit_preg  = t.commit_preg;
            @(posedge clk);
            #2;
            commit_valid = 1'b0;
        end
        waited = 0;
        @(posedge clk);
        #1;
        while (!in_ack && waited < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ack)
        begin
            errors++;
            $display("%s: in_ack never rose after in_req", t.name);
            in_req = 1'b0;
            return;
        end
        #1;
        if (t.wb_valid)
        begin
            wb_valid = 1'b1;
            wb_preg  = t.wb_preg;
        end
        @(negedge clk);
        check_bit({t.name, " out_req"}, 1'b1, out_req);
        check_op({t.name, " op"}, t.op, out_op);
        check_preg({t.name, " prs1"}, t.exp_prs1, out_prs1);
        check_preg({t.name, " prs2"}, t.exp_prs2, out_prs2);
        check_preg({t.name, " prd"}, t.exp_prd, out_prd);
        check_preg({t.name, " old_prd"}, t.exp_old_prd, out_old_prd);
        check_bit({t.name, " rd_valid"}, t.exp_prd != '0, out_rd_valid);
        check_imm({t.name, " imm"}, t.imm, out_imm);
        check_bit({t.name, " rs1_busy"}, t.exp_busy1, out_rs1_busy);
        check_bit({t.name, " rs2_busy"}, t.exp_busy2, out_rs2_busy);
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
        in_req   = 1'b0;
        waited   = 0;
        @(posedge clk);
        #1;
        while (in_ack && waited < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (in_ack)
        begin
            errors++;
            $display("%s: in_ack stayed high after in_req dropped", t.name);
        end
    endtask

    // consumer with random out_ack delay that checks the output holds still
    initial
    begin : consumer
        int unsigned delay;
        op_t   s_op;
        preg_t s_prs1;
        preg_t s_prs2;
        preg_t s_prd;
        preg_t s_old;
        imm_t  s_imm;
        int    waited;
        void'($urandom(32'ha088));
        out_ack = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack)
            begin
                outputs_seen++;
                s_op   = out_op;
                s_prs1 = out_prs1;
                s_prs2 = out_prs2;
                s_prd  = out_prd;
                s_old  = out_old_prd;
                s_imm  = out_imm;
                delay  = $urandom % 4;
                repeat (delay)
                begin
                    @(posedge clk);
                    #1;
                    check_bit("hold out_req", 1'b1, out_req);
                    check_op("hold op", s_op, out_op);
                    check_preg("hold prs1", s_prs1, out_prs1);
                    check_preg("hold prs2", s_prs2, out_prs2);
                    check_preg("hold prd", s_prd, out_prd);
                    check_preg("hold old_prd", s_old, out_old_prd);
                    check_imm("hold imm", s_imm, out_imm);
                end
                #1;
                out_ack = 1'b1;
                waited  = 0;
                @(posedge clk);
                #1;
                while (out_req && waited < ACK_LIMIT)
                begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                if (out_req)
                begin
                    errors++;
                    $display("out_req stayed high after out_ack rose");
                end
                #1;
                out_ack = 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        wait (table_ready);
        repeat (tests.size() * 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, a handshake is stuck", tests.size() * 50);
        $display("errors: %0d, outputs: %0d", errors + 1, outputs_seen);
        $display("tests failed");
        $finish;
    end

    initial
    begin : driver
        int waited;
        rst          = 1'b1;
        in_req       = 1'b0;
        in_op        = OP_NOP;
        in_rs1       = '0;
        in_rs2       = '0;
        in_rd        = '0;
        in_rd_valid  = 1'b0;
        in_imm       = '0;
        commit_valid = 1'b0;
        commit_preg  = '0;
        wb_valid     = 1'b0;
        wb_preg      = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_bit("reset in_ack", 1'b0, in_ack);
        check_bit("reset out_req", 1'b0, out_req);
        foreach (tests[i])
        begin
            apply_test(tests[i]);
        end
        // let the last output finish its return to zero
        waited = 0;
        while ((out_req || out_ack) && waited < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (2) @(posedge clk);
        if (outputs_seen != tests.size())
        begin
            errors++;
            $display("mismatch output count: expected %0d, actual %0d",
                     tests.size(), outputs_seen);
        end
        $display("errors: %0d, outputs: %0d", errors, outputs_seen);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/busy_table.sv
// busy_table, pending-result bit per physical register with writeback bypass

`default_nettype none

`include "rename_defs.svh"

module busy_table
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  set_en,
    input  preg_t set_preg,

    input  logic  clr_en,
    input  preg_t clr_preg,

    input  preg_t rd_a,
    input  preg_t rd_b,
    output logic  busy_a,
    output logic  busy_b
);

    logic [`PHY_REGS-1:0] busy_q;

    // a writeback in flight already counts as done
    assign busy_a = busy_q[rd_a] && !(clr_en && (clr_preg == rd_a));
    assign busy_b = busy_q[rd_b] && !(clr_en && (clr_preg == rd_b));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= '0;
        end
        else
        begin
            // phys 0 holds constant zero, never pending
            if (set_en && (set_preg != '0))
            begin
                busy_q[set_preg] <= 1'b1;
            end
            if (clr_en)
            begin
                busy_q[clr_preg] <= 1'b0;
            end
        end
    end

    // newly allocated register must have been written back before reuse
    assert property (@(posedge clk) disable iff (rst)
        set_en |-> !busy_q[set_preg])
        else $error("busy_table: set on busy preg %0d", set_preg);

endmodule

`default_nettype wire

// File: hw/free_list.sv
// free_list, bitmap of free physical registers with lowest-first allocation

`default_nettype none

`include "rename_defs.svh"

module free_list
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  alloc,
    output preg_t alloc_preg,
    output logic  empty,

    input  logic  release_en,
    input  preg_t release_preg
);

    // one bit per physical register, set means free
    logic [`PHY_REGS-1:0] free_map;

    // priority pick, scanning down so the lowest index wins
    always_comb
    begin
        alloc_preg = '0;
        for (int i = `PHY_REGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                alloc_preg = preg_t'(i);
            end
        end
    end

    assign empty = ~|free_map;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // x0..x31 own phys 0..31 out of reset
            free_map <= {{(`PHY_REGS - `LOG_REGS){1'b1}}, {`LOG_REGS{1'b0}}};
        end
        else
        begin
            // freed entry becomes visible to alloc on the next edge
            if (release_en)
            begin
                free_map[release_preg] <= 1'b1;
            end
            if (alloc && !empty)
            begin
                free_map[alloc_preg] <= 1'b0;
            end
        end
    end

    // commit must only hand back registers that are in flight
    assert property (@(posedge clk) disable iff (rst)
        release_en |-> !free_map[release_preg])
        else $error("free_list: release of free preg %0d", release_preg);

    // rename control has to stall on empty
    assert property (@(posedge clk) disable iff (rst)
        alloc |-> !empty)
        else $error("free_list: alloc while empty");

endmodule

`default_nettype wire

// File: hw/map_table.sv
// map_table, logical to physical mapping with identity reset and three read ports

`default_nettype none

`include "rename_defs.svh"

module map_table
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  lreg_t rs1,
    input  lreg_t rs2,
    input  lreg_t rd,
    output preg_t prs1,
    output preg_t prs2,
    output preg_t old_prd,

    input  logic  wr_en,
    input  preg_t wr_preg
);

    preg_t map_q [`LOG_REGS];

    // reads see the mapping before this cycle's write
    assign prs1    = map_q[rs1];
    assign prs2    = map_q[rs2];
    assign old_prd = map_q[rd];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `LOG_REGS; i++)
            begin
                map_q[i] <= preg_t'(i);
            end
        end
        else if (wr_en)
        begin
            map_q[rd] <= wr_preg;
        end
    end

    // x0 stays pinned to phys 0
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (rd != '0))
        else $error("map_table: write to x0 mapping");

endmodule

`default_nettype wire

// File: hw/rename_pkg.sv
// rename_pkg with logical and physical register, opcode and immediate types

`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`LREG_W-1:0] lreg_t;

    typedef logic [`PREG_W-1:0] preg_t;

    // opaque to rename, only passed along
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_ADD    = 4'h1,
        OP_SUB    = 4'h2,
        OP_AND    = 4'h3,
        OP_OR     = 4'h4,
        OP_XOR    = 4'h5,
        OP_SLL    = 4'h6,
        OP_SRL    = 4'h7,
        OP_SRA    = 4'h8,
        OP_SLT    = 4'h9,
        OP_ADDI   = 4'ha,
        OP_LOAD   = 4'hb,
        OP_STORE  = 4'hc,
        OP_BRANCH = 4'hd,
        OP_JAL    = 4'he,
        OP_LUI    = 4'hf
    } op_t;

    typedef logic [`IMM_W-1:0] imm_t;

endpackage

`default_nettype wire

// File: hw/rename_stage.sv
// four-phase micro-op handshakes, rename control and output registers

`default_nettype none

module rename_stage
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // decoded micro-op in
    input  logic  in_req,
    output logic  in_ack,
    input  op_t   in_op,
    input  lreg_t in_rs1,
    input  lreg_t in_rs2,
    input  lreg_t in_rd,
    input  logic  in_rd_valid,
    input  imm_t  in_imm,

    // renamed micro-op out
    output logic  out_req,
    input  logic  out_ack,
    output op_t   out_op,
    output preg_t out_prs1,
    output preg_t out_prs2,
    output preg_t out_prd,
    output preg_t out_old_prd,
    output logic  out_rd_valid,
    output imm_t  out_imm,

    // retirement
    input  logic  commit_valid,
    input  preg_t commit_preg,

    // busy table update
    output logic  busy_set,
    output preg_t busy_set_preg
);

    logic  need_rd;
    logic  out_idle;
    logic  fire;
    logic  do_alloc;

    preg_t fl_preg;
    logic  fl_empty;

    preg_t map_prs1;
    preg_t map_prs2;
    preg_t map_old_prd;

    // x0 writes are dropped and use no register
    assign need_rd  = in_rd_valid && (in_rd != '0);

    // previous output fully returned to zero
    assign out_idle = !out_req && !out_ack;

    assign fire     = in_req && !in_ack && out_idle && (!need_rd || !fl_empty);
    assign do_alloc = fire && need_rd;

    assign busy_set      = do_alloc;
    assign busy_set_preg = fl_preg;

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .alloc        (do_alloc),
        .alloc_preg   (fl_preg),
        .empty        (fl_empty),
        .release_en   (commit_valid),
        .release_preg (commit_preg)
    );

    map_table u_map_table (
        .clk     (clk),
        .rst     (rst),
        .rs1     (in_rs1),
        .rs2     (in_rs2),
        .rd      (in_rd),
        .prs1    (map_prs1),
        .prs2    (map_prs2),
        .old_prd (map_old_prd),
        .wr_en   (do_alloc),
        .wr_preg (fl_preg)
    );

    // handshake sequencing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end
        else
        begin
            if (fire)
                in_ack <= 1'b1;
            else if (!in_req)
                in_ack <= 1'b0;

            if (fire)
                out_req <= 1'b1;
            else if (out_ack)
                out_req <= 1'b0;
        end
    end

    // renamed fields held until the next rename
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            out_op       <= in_op;
            out_prs1     <= map_prs1;
            out_prs2     <= map_prs2;
            out_prd      <= need_rd ? fl_preg : '0;
            out_old_prd  <= need_rd ? map_old_prd : '0;
            out_rd_valid <= need_rd;
            out_imm      <= in_imm;
        end
    end

    // consumer raises out_ack only against a pending out_req
    assert property (@(posedge clk) disable iff (rst)
        $rose(out_ack) |-> out_req)
        else $error("rename_stage: out_ack raised without out_req");

endmodule

`default_nettype wire

// File: hw/rename_top.sv
// rename_top, rename stage with the busy table on the renamed sources

`default_nettype none

module rename_top
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  in_req,
    output logic  in_ack,
    input  op_t   in_op,
    input  lreg_t in_rs1,
    input  lreg_t in_rs2,
    input  lreg_t in_rd,
    input  logic  in_rd_valid,
    input  imm_t  in_imm,

    output logic  out_req,
    input  logic  out_ack,
    output op_t   out_op,
    output preg_t out_prs1,
    output preg_t out_prs2,
    output preg_t out_prd,
    output preg_t out_old_prd,
    output logic  out_rd_valid,
    output imm_t  out_imm,
    output logic  out_rs1_busy,
    output logic  out_rs2_busy,

    input  logic  commit_valid,
    input  preg_t commit_preg,

    input  logic  wb_valid,
    input  preg_t wb_preg
);

    logic  busy_set;
    preg_t busy_set_preg;

    rename_stage u_rename_stage (
        .clk           (clk),
        .rst           (rst),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .in_op         (in_op),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_rd         (in_rd),
        .in_rd_valid   (in_rd_valid),
        .in_imm        (in_imm),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_op        (out_op),
        .out_prs1      (out_prs1),
        .out_prs2      (out_prs2),
        .out_prd       (out_prd),
        .out_old_prd   (out_old_prd),
        .out_rd_valid  (out_rd_valid),
        .out_imm       (out_imm),
        .commit_valid  (commit_valid),
        .commit_preg   (commit_preg),
        .busy_set      (busy_set),
        .busy_set_preg (busy_set_preg)
    );

    // status of the registered sources
    busy_table u_busy_table (
        .clk      (clk),
        .rst      (rst),
        .set_en   (busy_set),
        .set_preg (busy_set_preg),
        .clr_en   (wb_valid),
        .clr_preg (wb_preg),
        .rd_a     (out_prs1),
        .rd_b     (out_prs2),
        .busy_a   (out_rs1_busy),
        .busy_b   (out_rs2_busy)
    );

endmodule

`default_nettype wire

// File: include/rename_defs.svh
// register counts and index widths for the rename subsystem

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// architectural registers x0..x31
`define LOG_REGS 32

// physical pool, must be larger than LOG_REGS
`define PHY_REGS 64

// index widths
`define LREG_W 5
`define PREG_W 6

// immediate carried through rename untouched
`define IMM_W 32

`endif

// File: vlog.f
+incdir+include
hw/rename_pkg.sv
hw/free_list.sv
hw/map_table.sv
hw/busy_table.sv
hw/rename_stage.sv
hw/rename_top.sv
bench/rename_tb.sv
